// File: src/conv_types_pkg.sv
package conv_types_pkg;

    localparam int PIXEL_WIDTH  = 16;
    localparam int KERNEL_WIDTH = 16;
    localparam int RESULT_WIDTH = 48;

    // Full precision of one pixel times one weight
    localparam int PRODUCT_WIDTH = PIXEL_WIDTH + KERNEL_WIDTH;

    typedef logic signed [PIXEL_WIDTH-1:0]  pixel_t;
    typedef logic signed [KERNEL_WIDTH-1:0] weight_t;
    typedef logic signed [RESULT_WIDTH-1:0] result_t;

    // 3x3 window, row-major, x00 in the top bits
    typedef struct packed {
        pixel_t x00;
        pixel_t x01;
        pixel_t x02;
        pixel_t x10;
        pixel_t x11;
        pixel_t x12;
        pixel_t x20;
        pixel_t x21;
        pixel_t x22;
    } window_t;

    // Kernel coefficients in the same order as the window
    typedef struct packed {
        weight_t k00;
        weight_t k01;
        weight_t k02;
        weight_t k10;
        weight_t k11;
        weight_t k12;
        weight_t k20;
        weight_t k21;
        weight_t k22;
    } kernel_t;

endpackage

// File: src/pe_ctrl_pkg.sv
package pe_ctrl_pkg;

    // Enough for rows of up to 1024 output pixels
    localparam int ADDR_WIDTH = 10;

    typedef enum logic [1:0] {
        // No kernel loaded since reset
        NO_KERNEL = 2'd0,
        // Kernel held, pipeline empty
        READY     = 2'd1,
        // Accepting windows of a channel-row
        STREAM    = 2'd2,
        // Row complete, waiting for the pipeline to empty
        DRAIN     = 2'd3
    } pe_state_e;

    // Per-window command, travels alongside the MAC pipeline
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        // Ignore the stored partial sum
        logic                  first;
        // Add bias and emit the result
        logic                  last;
        // Final pixel of the row
        logic                  tail;
    } psum_cmd_t;

endpackage

// File: src/conv_mac_3x3.sv
`timescale 1ns/1ps

module conv_mac_3x3 (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    kernel_wr,
    input  conv_types_pkg::kernel_t kernel,
    input  conv_types_pkg::window_t window,
    input  logic                    window_valid,
    output conv_types_pkg::result_t mac_sum,
    output logic                    mac_valid
);

    localparam int TAPS = 9;

    typedef logic signed [conv_types_pkg::PRODUCT_WIDTH-1:0] product_t;

    conv_types_pkg::kernel_t kernel_q;

    // Window and kernel seen as tap arrays, x00 and k00 at index 8
    conv_types_pkg::pixel_t  [TAPS-1:0] pix_taps;
    conv_types_pkg::weight_t [TAPS-1:0] wgt_taps;

    product_t                prod_q [TAPS];
    logic                    prod_valid;
    conv_types_pkg::result_t tree_sum;

    assign pix_taps = window;
    assign wgt_taps = kernel_q;

    // Kernel register, a write takes effect for the next window
    always_ff @(posedge clk) begin
        if (kernel_wr) begin
            kernel_q <= kernel;
        end
    end

    // Stage 1: nine signed products
    always_ff @(posedge clk) begin
        if (window_valid) begin
            for (int i = 0; i < TAPS; i++) begin
                prod_q[i] <= product_t'(pix_taps[i]) * product_t'(wgt_taps[i]);
            end
        end
    end

    // Adder tree over the sign-extended products
    always_comb begin
        tree_sum = '0;
        for (int i = 0; i < TAPS; i++) begin
            tree_sum = tree_sum + conv_types_pkg::result_t'(prod_q[i]);
        end
    end

    // Stage 2: registered sum
    always_ff @(posedge clk) begin
        if (prod_valid) begin
            mac_sum <= tree_sum;
        end
    end

    // Valid bits follow the data through both stages
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prod_valid <= 1'b0;
            mac_valid  <= 1'b0;
        end else begin
            prod_valid <= window_valid;
            mac_valid  <= prod_valid;
        end
    end

endmodule

// File: src/psum_buffer.sv
`timescale 1ns/1ps

module psum_buffer #(
    parameter int ROW_LENGTH = 8
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  pe_ctrl_pkg::psum_cmd_t  cmd,
    input  logic                    cmd_valid,
    input  conv_types_pkg::result_t mac_sum,
    input  logic                    mac_valid,
    input  conv_types_pkg::result_t bias,
    output conv_types_pkg::result_t result,
    output logic                    m_axis_tvalid,
    output logic                    m_axis_tlast,
    output logic                    busy
);

    localparam int MEM_AW = $clog2(ROW_LENGTH);

    conv_types_pkg::result_t psum_mem [ROW_LENGTH];

    logic [MEM_AW-1:0]       rd_addr;
    logic [MEM_AW-1:0]       wr_addr;
    conv_types_pkg::result_t old_psum;
    pe_ctrl_pkg::psum_cmd_t  cmd_q;
    logic                    cmd_q_valid;

    conv_types_pkg::result_t base_psum;
    conv_types_pkg::result_t bias_term;
    conv_types_pkg::result_t new_psum;
    logic                    wr_en;
    logic                    emit;

    assign rd_addr = cmd.addr[MEM_AW-1:0];
    assign wr_addr = cmd_q.addr[MEM_AW-1:0];

    // Read stage, old partial sum lines up with mac_sum next cycle
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            old_psum <= psum_mem[rd_addr];
            cmd_q    <= cmd;
        end
    end

    assign wr_en = cmd_q_valid && mac_valid;
    assign emit  = wr_en && cmd_q.last;

    // Accumulate, first channel starts from zero, bias only on the last one
    always_comb begin
        base_psum = cmd_q.first ? '0 : old_psum;
        bias_term = cmd_q.last ? bias : '0;
        new_psum  = base_psum + mac_sum + bias_term;
    end

    // Write back to the address that was read
    always_ff @(posedge clk) begin
        if (wr_en) begin
            psum_mem[wr_addr] <= new_psum;
        end
    end

    // Output data register
    always_ff @(posedge clk) begin
        if (emit) begin
            result <= new_psum;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cmd_q_valid   <= 1'b0;
            m_axis_tvalid <= 1'b0;
            m_axis_tlast  <= 1'b0;
        end else begin
            cmd_q_valid   <= cmd_valid;
            m_axis_tvalid <= emit;
            m_axis_tlast  <= emit && cmd_q.tail;
        end
    end

    // Something still sits in the read, accumulate or output stage
    assign busy = cmd_valid || cmd_q_valid || m_axis_tvalid;

endmodule

// File: src/pe_control.sv
`timescale 1ns/1ps

module pe_control #(
    parameter int ROW_LENGTH = 8
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   load_kernel,
    input  logic                   window_valid,
    input  logic                   first_channel,
    input  logic                   last_channel,
    input  logic                   busy,
    output logic                   kernel_wr,
    output pe_ctrl_pkg::psum_cmd_t cmd,
    output logic                   cmd_valid,
    output logic                   pe_ready,
    output logic                   pe_idle
);

    typedef logic [pe_ctrl_pkg::ADDR_WIDTH-1:0] addr_t;

    localparam addr_t LAST_ADDR = addr_t'(ROW_LENGTH - 1);

    pe_ctrl_pkg::pe_state_e state;
    pe_ctrl_pkg::pe_state_e state_next;

    addr_t addr_cnt;
    logic  accept;
    logic  row_end;

    // Status outputs straight from the state
    assign pe_ready = (state == pe_ctrl_pkg::READY) || (state == pe_ctrl_pkg::STREAM);
    assign pe_idle  = (state == pe_ctrl_pkg::NO_KERNEL) ||
                      ((state == pe_ctrl_pkg::READY) && !busy);

    // The very first kernel must be accepted before pe_ready can rise
    assign kernel_wr = load_kernel &&
                       (pe_ready || (state == pe_ctrl_pkg::NO_KERNEL));

    assign accept  = window_valid && pe_ready;
    assign row_end = (addr_cnt == LAST_ADDR);

    always_comb begin
        state_next = state;
        case (state)
            pe_ctrl_pkg::NO_KERNEL: begin
                if (kernel_wr) begin
                    state_next = pe_ctrl_pkg::READY;
                end
            end
            pe_ctrl_pkg::READY: begin
                if (accept) begin
                    state_next = row_end ? pe_ctrl_pkg::DRAIN : pe_ctrl_pkg::STREAM;
                end
            end
            pe_ctrl_pkg::STREAM: begin
                if (accept && row_end) begin
                    state_next = pe_ctrl_pkg::DRAIN;
                end
            end
            pe_ctrl_pkg::DRAIN: begin
                // Wait for the last write-back and output to leave the buffer
                if (!busy) begin
                    state_next = pe_ctrl_pkg::READY;
                end
            end
            default: begin
                state_next = pe_ctrl_pkg::NO_KERNEL;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= pe_ctrl_pkg::NO_KERNEL;
        end else begin
            state <= state_next;
        end
    end

    // Buffer address, one step per accepted window
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            addr_cnt <= '0;
        end else if (accept) begin
            if (row_end) begin
                addr_cnt <= '0;
            end else begin
                addr_cnt <= addr_cnt + addr_t'(1);
            end
        end
    end

    // Command for the window sampled this cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd.addr  <= addr_cnt;
            cmd.first <= first_channel;
            cmd.last  <= last_channel;
            cmd.tail  <= row_end;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= accept;
        end
    end

endmodule

// File: src/pe_with_buffers.sv
`timescale 1ns/1ps

module pe_with_buffers #(
    parameter int ROW_LENGTH = 8
) (
    input  logic                    clk,
    input  logic                    arst_n,
    // Window stream from the line buffer
    input  conv_types_pkg::window_t window,
    input  logic                    window_valid,
    input  logic                    first_channel,
    input  logic                    last_channel,
    // Kernel and bias
    input  conv_types_pkg::kernel_t kernel,
    input  logic                    load_kernel,
    input  conv_types_pkg::result_t bias,
    // Result stream, no back-pressure
    output conv_types_pkg::result_t result,
    output logic                    m_axis_tvalid,
    output logic                    m_axis_tlast,
    // Status
    output logic                    pe_ready,
    output logic                    pe_idle
);

    logic                    kernel_wr;
    pe_ctrl_pkg::psum_cmd_t  cmd;
    logic                    cmd_valid;
    conv_types_pkg::result_t mac_sum;
    logic                    mac_valid;
    logic                    busy;

    pe_control #(
        .ROW_LENGTH(ROW_LENGTH)
    ) u_control (
        .clk          (clk),
        .arst_n       (arst_n),
        .load_kernel  (load_kernel),
        .window_valid (window_valid),
        .first_channel(first_channel),
        .last_channel (last_channel),
        .busy         (busy),
        .kernel_wr    (kernel_wr),
        .cmd          (cmd),
        .cmd_valid    (cmd_valid),
        .pe_ready     (pe_ready),
        .pe_idle      (pe_idle)
    );

    conv_mac_3x3 u_mac (
        .clk         (clk),
        .arst_n      (arst_n),
        .kernel_wr   (kernel_wr),
        .kernel      (kernel),
        .window      (window),
        .window_valid(window_valid),
        .mac_sum     (mac_sum),
        .mac_valid   (mac_valid)
    );

    psum_buffer #(
        .ROW_LENGTH(ROW_LENGTH)
    ) u_psum (
        .clk          (clk),
        .arst_n       (arst_n),
        .cmd          (cmd),
        .cmd_valid    (cmd_valid),
        .mac_sum      (mac_sum),
        .mac_valid    (mac_valid),
        .bias         (bias),
        .result       (result),
        .m_axis_tvalid(m_axis_tvalid),
        .m_axis_tlast (m_axis_tlast),
        .busy         (busy)
    );

endmodule

// File: testbench/pe_with_buffers_checker.sv
`timescale 1ns/1ps

module pe_with_buffers_checker (
    input logic clk,
    input logic arst_n,
    input logic window_valid,
    input logic last_channel,
    input logic pe_ready,
    input logic pe_idle,
    input logic m_axis_tvalid,
    input logic m_axis_tlast
);

    int assert_failures = 0;

    a_tlast_with_tvalid: assert property (@(posedge clk) disable iff (!arst_n)
        m_axis_tlast |-> m_axis_tvalid)
        else begin assert_failures++; $error("tlast without tvalid"); end

    a_window_when_ready: assert property (@(posedge clk) disable iff (!arst_n)
        window_valid |-> pe_ready)
        else begin assert_failures++; $error("window_valid while pe_ready low"); end

    // Fixed three-cycle latency on the last channel
    a_output_latency: assert property (@(posedge clk) disable iff (!arst_n)
        (window_valid && last_channel) |-> ##3 m_axis_tvalid)
        else begin assert_failures++; $error("result not valid 3 cycles after window"); end

    a_reset_levels: assert property (@(posedge clk)
        $rose(arst_n) |-> (!pe_ready && pe_idle))
        else begin assert_failures++; $error("status outputs wrong after reset"); end

endmodule

// File: testbench/tb_pe_with_buffers.sv
`timescale 1ns/1ps

module tb_pe_with_buffers;

    localparam int ROW_LENGTH      = 8;
    localparam int TOTAL_WINDOWS   = 8 * ROW_LENGTH;
    localparam int WATCHDOG_CYCLES = TOTAL_WINDOWS * 4 + 200;
    localparam int WAIT_LIMIT      = 100;

    typedef struct packed {
        conv_types_pkg::result_t value;
        logic                    tlast;
    } expected_t;

    logic                    clk;
    logic                    arst_n;
    conv_types_pkg::window_t window;
    logic                    window_valid;
    logic                    first_channel;
    logic                    last_channel;
    conv_types_pkg::kernel_t kernel;
    logic                    load_kernel;
    conv_types_pkg::result_t bias;
    conv_types_pkg::result_t result;
    logic                    m_axis_tvalid;
    logic                    m_axis_tlast;
    logic                    pe_ready;
    logic                    pe_idle;

    // Reference model state
    conv_types_pkg::kernel_t cur_kernel;
    longint                  acc [ROW_LENGTH];
    expected_t               exp_q [$];
    expected_t               exp_item;

    int          errors       = 0;
    int          outputs_seen = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          test_err_base;
    int          test_out_base;

    pe_with_buffers #(
        .ROW_LENGTH(ROW_LENGTH)
    ) dut (.*);

    bind pe_with_buffers pe_with_buffers_checker u_checker (
        .clk          (clk),
        .arst_n       (arst_n),
        .window_valid (window_valid),
        .last_channel (last_channel),
        .pe_ready     (pe_ready),
        .pe_idle      (pe_idle),
        .m_axis_tvalid(m_axis_tvalid),
        .m_axis_tlast (m_axis_tlast)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    function automatic int total_errors();
        return errors + dut.u_checker.assert_failures;
    endfunction

    // Outputs change on the rising edge and are sampled on the falling one
    always @(negedge clk) begin
        if (arst_n && m_axis_tvalid) begin
            outputs_seen++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("Unexpected result at %0t ns with none predicted", $time);
            end else begin
                exp_item = exp_q.pop_front();
                check_value("result", 64'(result), 64'(exp_item.value));
                check_value("m_axis_tlast", 64'(m_axis_tlast), 64'(exp_item.tlast));
            end
        end
    end

    function automatic longint dot3x3(input conv_types_pkg::window_t w,
                                      input conv_types_pkg::kernel_t k);
        longint s;
        s = longint'(w.x00) * longint'(k.k00) + longint'(w.x01) * longint'(k.k01);
        s += longint'(w.x02) * longint'(k.k02) + longint'(w.x10) * longint'(k.k10);
        s += longint'(w.x11) * longint'(k.k11) + longint'(w.x12) * longint'(k.k12);
        s += longint'(w.x20) * longint'(k.k20) + longint'(w.x21) * longint'(k.k21);
        s += longint'(w.x22) * longint'(k.k22);
        return s;
    endfunction

    function automatic logic [143:0] random_taps();
        logic [143:0] v;
        for (int i = 0; i < 9; i++) begin
            v[i*16 +: 16] = 16'($urandom);
        end
        return v;
    endfunction

    task automatic wait_for(input string what, input logic want_idle);
        int n;
        n = 0;
        @(negedge clk);
        while (!(want_idle ? pe_idle : pe_ready) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!(want_idle ? pe_idle : pe_ready)) begin
            errors++;
            $display("Timed out at %0t ns waiting for %s", $time, what);
        end
    endtask

    task automatic load_new_kernel();
        @(negedge clk);
        cur_kernel  = conv_types_pkg::kernel_t'(random_taps());
        kernel      = cur_kernel;
        load_kernel = 1'b1;
        @(negedge clk);
        load_kernel = 1'b0;
    endtask

    // One channel-row with up to max_gap idle cycles between windows
    task automatic run_row(input logic first, input logic last, input int max_gap);
        conv_types_pkg::window_t w;
        longint                  mac;
        int                      gap;
        expected_t               item;
        wait_for("pe_ready before a row", 1'b0);
        for (int p = 0; p < ROW_LENGTH; p++) begin
            w      = conv_types_pkg::window_t'(random_taps());
            mac    = dot3x3(w, cur_kernel);
            acc[p] = first ? mac : acc[p] + mac;
            if (last) begin
                acc[p]     = acc[p] + longint'(bias);
                item.value = conv_types_pkg::result_t'(acc[p]);
                item.tlast = (p == ROW_LENGTH - 1);
                exp_q.push_back(item);
            end
            @(negedge clk);
            window        = w;
            window_valid  = 1'b1;
            first_channel = first;
            last_channel  = last;
            gap = (max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
            if (gap > 0) begin
                @(negedge clk);
                window_valid = 1'b0;
                repeat (gap - 1) @(negedge clk);
            end
        end
        @(negedge clk);
        window_valid = 1'b0;
    endtask

    task automatic new_bias();
        bias = conv_types_pkg::result_t'($signed($urandom));
    endtask

    task automatic start_test();
        test_err_base = total_errors();
        test_out_base = outputs_seen;
    endtask

    task automatic end_test(input string name, input int n_outputs);
        wait_for("pe_idle at test end", 1'b1);
        @(negedge clk);
        check_value("pending predictions", 64'(exp_q.size()), 64'(0));
        check_value("output count", 64'(outputs_seen - test_out_base), 64'(n_outputs));
        tests_run++;
        if (total_errors() != test_err_base) begin
            tests_failed++;
            $display("%s: FAIL", name);
        end else begin
            $display("%s: PASS", name);
        end
    endtask

    task automatic test_reset_state();
        start_test();
        check_value("m_axis_tvalid", 64'(m_axis_tvalid), 64'(0));
        check_value("m_axis_tlast", 64'(m_axis_tlast), 64'(0));
        check_value("pe_ready", 64'(pe_ready), 64'(0));
        check_value("pe_idle", 64'(pe_idle), 64'(1));
        load_new_kernel();
        check_value("pe_ready after kernel load", 64'(pe_ready), 64'(1));
        end_test("reset_state", 0);
    endtask

    task automatic test_single_channel();
        start_test();
        wait_for("pe_ready", 1'b0);
        load_new_kernel();
        new_bias();
        run_row(1'b1, 1'b1, 0);
        end_test("single_channel", ROW_LENGTH);
    endtask

    task automatic test_multi_channel();
        start_test();
        new_bias();
        for (int c = 0; c < 3; c++) begin
            wait_for("pe_ready", 1'b0);
            load_new_kernel();
            run_row(c == 0, c == 2, 0);
        end
        end_test("multi_channel", ROW_LENGTH);
    endtask

    task automatic test_random_stream();
        start_test();
        wait_for("pe_ready", 1'b0);
        load_new_kernel();
        new_bias();
        run_row(1'b1, 1'b1, 0);
        run_row(1'b1, 1'b1, 3);
        end_test("random_stream", 2 * ROW_LENGTH);
    endtask

    task automatic test_second_row();
        start_test();
        wait_for("pe_ready", 1'b0);
        load_new_kernel();
        new_bias();
        run_row(1'b1, 1'b0, 0);
        wait_for("pe_ready", 1'b0);
        load_new_kernel();
        run_row(1'b1, 1'b1, 1);
        end_test("second_row", ROW_LENGTH);
    endtask

    initial begin
        void'($urandom(32'h2b47_2097));
        arst_n        = 1'b0;
        window        = '0;
        window_valid  = 1'b0;
        first_channel = 1'b0;
        last_channel  = 1'b0;
        kernel        = '0;
        load_kernel   = 1'b0;
        bias          = '0;
        cur_kernel    = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        test_reset_state();
        test_single_channel();
        test_multi_channel();
        test_random_stream();
        test_second_row();

        $display("Summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 tests_run, tests_failed, errors, dut.u_checker.assert_failures);
        if (total_errors() == 0 && tests_failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: sources.f
src/conv_types_pkg.sv
src/pe_ctrl_pkg.sv
src/conv_mac_3x3.sv
src/psum_buffer.sv
src/pe_control.sv
src/pe_with_buffers.sv
testbench/pe_with_buffers_checker.sv
testbench/tb_pe_with_buffers.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the PE testbench with Verilator, then look for the pass line
cd "$(dirname "$0")" || exit 1
LOG=sim.log
verilator --binary --timing --assert --top-module tb_pe_with_buffers \
    -f sources.f -o sim_pe > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
# Keep running after assertion errors so the testbench prints its summary
./obj_dir/sim_pe +verilator+error+limit+1000 > "$LOG" 2>&1
cat "$LOG"
grep -qx "Simulation passed" "$LOG" && exit 0 || exit 1
